// File: Makefile
# Verilator simulation of the two-lane AXI bridge

TOP = tb_axi_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

// File: bench/axi_mem_model.sv
// AXI4 memory responder
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module axi_mem_model #(
  parameter int          read_lat_p = 2,
  parameter logic [15:0] seed_p     = 16'd41280
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  axi_bridge_pkg::axi_aw_t aw_i,
  input  logic                    aw_v_i,
  output logic                    aw_ready_o,
  input  axi_bridge_pkg::axi_w_t  w_i,
  input  logic                    w_v_i,
  output logic                    w_ready_o,
  output axi_bridge_pkg::axi_b_t  b_o,
  output logic                    b_v_o,
  input  logic                    b_ready_i,
  input  axi_bridge_pkg::axi_ar_t ar_i,
  input  logic                    ar_v_i,
  output logic                    ar_ready_o,
  output axi_bridge_pkg::axi_r_t  r_o,
  output logic                    r_v_o,
  input  logic                    r_ready_i
);

  logic [`AB_DATA_W-1:0] mem [logic [`AB_ADDR_W-1:0]];
  logic [15:0]           lfsr;
  logic [`AB_DATA_W-1:0] r_data;

  assign b_o = '0;
  assign r_o = '{data: r_data, id: 1'b0, resp: 2'b00, last: 1'b1};

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // ready three times out of four
  task automatic draw_ready(output logic rdy);
    logic [1:0] bits;
    for (int k = 0; k < 2; k++) begin
      lfsr    = lfsr_step(lfsr);
      bits[k] = lfsr[0];
    end
    rdy = |bits;
  endtask

  // unwritten words hold a pattern of their own address
  function automatic logic [`AB_DATA_W-1:0] load_word(input logic [`AB_ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a ^ 32'h3c5a_96e1, ~a};
  endfunction

  initial begin : respond
    logic                    in_rst;
    logic                    aw_f, w_f, ar_f, r_f, b_f;
    logic                    aw_have, w_have, b_pend, r_busy;
    logic [`AB_ADDR_W-1:0]   aw_addr, ar_addr;
    axi_bridge_pkg::axi_w_t  beat;
    logic [`AB_DATA_W-1:0]   word;
    int                      r_wait;
    lfsr       = seed_p;
    aw_have    = 1'b0;
    w_have     = 1'b0;
    b_pend     = 1'b0;
    r_busy     = 1'b0;
    r_wait     = 0;
    r_data     = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_v_o      = 1'b0;
    r_v_o      = 1'b0;
    forever begin
      // mid-cycle, find the handshakes of the coming edge
      @(negedge clk_i);
      in_rst = !arst_n_i;
      aw_f   = aw_v_i & aw_ready_o;
      w_f    = w_v_i & w_ready_o;
      ar_f   = ar_v_i & ar_ready_o;
      r_f    = r_v_o & r_ready_i;
      b_f    = b_v_o & b_ready_i;
      if (aw_f) begin
        aw_addr = {aw_i.addr[`AB_ADDR_W-1:3], 3'b000};
      end
      if (w_f) begin
        beat = w_i;
      end
      if (ar_f) begin
        ar_addr = {ar_i.addr[`AB_ADDR_W-1:3], 3'b000};
      end
      @(posedge clk_i);
      #1;
      if (in_rst) begin
        aw_have = 1'b0;
        w_have  = 1'b0;
        b_pend  = 1'b0;
        r_busy  = 1'b0;
      end else begin
        aw_have = aw_have | aw_f;
        w_have  = w_have | w_f;
        if (b_f) begin
          b_pend = 1'b0;
        end
        // commit the write once address and data are both here
        if (aw_have && w_have && !b_pend) begin
          word = load_word(aw_addr);
          for (int k = 0; k < `AB_STRB_W; k++) begin
            if (beat.strb[k]) begin
              word[8*k +: 8] = beat.data[8*k +: 8];
            end
          end
          mem[aw_addr] = word;
          aw_have      = 1'b0;
          w_have       = 1'b0;
          b_pend       = 1'b1;
        end
        if (r_f) begin
          r_busy = 1'b0;
        end
        // data is taken at acceptance, only the valid is delayed
        if (ar_f) begin
          r_busy = 1'b1;
          r_wait = read_lat_p;
          r_data = load_word(ar_addr);
        end else if (r_busy && r_wait != 0) begin
          r_wait--;
        end
      end
      draw_ready(aw_ready_o);
      draw_ready(w_ready_o);
      draw_ready(ar_ready_o);
      aw_ready_o = aw_ready_o & !aw_have;
      w_ready_o  = w_ready_o & !w_have;
      ar_ready_o = ar_ready_o & !r_busy;
      b_v_o      = b_pend;
      r_v_o      = r_busy && (r_wait == 0);
    end
  end

endmodule

// File: bench/tb_axi_bridge.sv
// Two-lane AXI bridge testbench
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module tb_axi_bridge;

  localparam int num_req_c = 400;

  logic                      clk;
  logic                      arst_n;
  axi_bridge_pkg::fifo_req_t req;
  logic                      req_v, req_ready;
  logic [`AB_DATA_W-1:0]     rsp_data;
  logic                      rsp_v, rsp_ready;
  axi_bridge_pkg::axi_aw_t   aw [`AB_LANES];
  axi_bridge_pkg::axi_w_t    w [`AB_LANES];
  axi_bridge_pkg::axi_b_t    b [`AB_LANES];
  axi_bridge_pkg::axi_ar_t   ar [`AB_LANES];
  axi_bridge_pkg::axi_r_t    r [`AB_LANES];
  logic [`AB_LANES-1:0]      aw_v, aw_rdy;
  logic [`AB_LANES-1:0]      w_v, w_rdy;
  logic [`AB_LANES-1:0]      b_v, b_rdy;
  logic [`AB_LANES-1:0]      ar_v, ar_rdy;
  logic [`AB_LANES-1:0]      r_v, r_rdy;

  logic [15:0]               lfsr;
  logic [`AB_DATA_W-1:0]     shadow [logic [`AB_ADDR_W-1:0]];
  axi_bridge_pkg::fifo_req_t ax_q [`AB_LANES][$];
  axi_bridge_pkg::fifo_req_t wd_q [`AB_LANES][$];
  logic [`AB_DATA_W-1:0]     rsp_q [$];
  axi_bridge_pkg::fifo_req_t ax_head [`AB_LANES];
  axi_bridge_pkg::fifo_req_t wd_head [`AB_LANES];
  logic [`AB_LANES-1:0]      ax_any, wd_any, ax_fire, wd_fire;
  logic [`AB_DATA_W-1:0]     rsp_exp;
  logic                      rsp_any, seen_req, req_fire, rsp_fire;
  axi_bridge_pkg::fifo_req_t req_seen;
  int                        read_count, rsp_count;

  axi_bridge_top i_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_i       (req),
    .req_v_i     (req_v),
    .req_ready_o (req_ready),
    .rsp_data_o  (rsp_data),
    .rsp_v_o     (rsp_v),
    .rsp_ready_i (rsp_ready),
    .aw_o        (aw),
    .aw_v_o      (aw_v),
    .aw_ready_i  (aw_rdy),
    .w_o         (w),
    .w_v_o       (w_v),
    .w_ready_i   (w_rdy),
    .b_i         (b),
    .b_v_i       (b_v),
    .b_ready_o   (b_rdy),
    .ar_o        (ar),
    .ar_v_o      (ar_v),
    .ar_ready_i  (ar_rdy),
    .r_i         (r),
    .r_v_i       (r_v),
    .r_ready_o   (r_rdy)
  );

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "stopped at the first failure");
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // bytes written for a size and a byte offset
  function automatic logic [`AB_STRB_W-1:0] byte_enables(input logic [2:0] size,
                                                         input logic [2:0] off);
    logic [`AB_STRB_W-1:0] en;
    en = '0;
    for (int k = 0; k < `AB_STRB_W; k++) begin
      if (size == 3'd3 || (k >= int'(off) && k < int'(off) + (1 << size))) begin
        en[k] = 1'b1;
      end
    end
    return en;
  endfunction

  function automatic logic [`AB_DATA_W-1:0] word_at(input logic [`AB_ADDR_W-1:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return {a ^ 32'h3c5a_96e1, ~a};
  endfunction

  // update the prediction for an accepted request
  task automatic accept(input axi_bridge_pkg::fifo_req_t rq);
    logic [`AB_ADDR_W-1:0] a;
    logic [`AB_DATA_W-1:0] word;
    logic [`AB_STRB_W-1:0] en;
    int                    lane;
    a    = {rq.addr[`AB_ADDR_W-1:3], 3'b000};
    word = word_at(a);
    en   = byte_enables(rq.size, rq.addr[2:0]);
    lane = int'(rq.addr[`AB_LANE_BIT]);
    ax_q[lane].push_back(rq);
    seen_req = 1'b1;
    if (rq.w) begin
      for (int k = 0; k < `AB_STRB_W; k++) begin
        if (en[k]) begin
          word[8*k +: 8] = rq.data[8*k +: 8];
        end
      end
      shadow[a] = word;
      wd_q[lane].push_back(rq);
    end else begin
      rsp_q.push_back(word);
      read_count++;
    end
  endtask

  task automatic next_cycle();
    logic [31:0] v;
    @(posedge clk);
    #1;
    draw(2, v);
    rsp_ready = |v[1:0];
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // bookkeeping runs mid-cycle so expectations are steady at each edge
  always @(negedge clk) begin
    if (req_fire) begin
      accept(req_seen);
    end
    if (rsp_fire) begin
      void'(rsp_q.pop_front());
      rsp_count++;
    end
    for (int l = 0; l < `AB_LANES; l++) begin
      if (ax_fire[l]) begin
        void'(ax_q[l].pop_front());
      end
      if (wd_fire[l]) begin
        void'(wd_q[l].pop_front());
      end
      ax_any[l]  = (ax_q[l].size() != 0);
      wd_any[l]  = (wd_q[l].size() != 0);
      ax_head[l] = ax_any[l] ? ax_q[l][0] : '0;
      wd_head[l] = wd_any[l] ? wd_q[l][0] : '0;
      ax_fire[l] = (aw_v[l] & aw_rdy[l]) | (ar_v[l] & ar_rdy[l]);
      wd_fire[l] = w_v[l] & w_rdy[l];
    end
    rsp_any  = (rsp_q.size() != 0);
    rsp_exp  = rsp_any ? rsp_q[0] : '0;
    req_fire = req_v & req_ready;
    req_seen = req;
    rsp_fire = rsp_v & rsp_ready;
  end

  a_idle_until_req: assert property (@(posedge clk) disable iff (!arst_n)
    !seen_req |-> (aw_v == '0) && (w_v == '0) && (ar_v == '0) && !rsp_v)
    else fail_run($sformatf("[ERROR] %0t: valid raised before any request", $time));
  a_rsp_data: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp_v && rsp_ready) |-> rsp_any && (rsp_data == rsp_exp))
    else fail_run($sformatf("[ERROR] %0t: read data wrong, expected %h", $time, rsp_exp));
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp_v && !rsp_ready) |=> rsp_v && $stable(rsp_data))
    else fail_run($sformatf("[ERROR] %0t: read data dropped while waiting", $time));

  for (genvar g = 0; g < `AB_LANES; g++) begin : g_lane
    // lane 0 answers reads slower than lane 1
    axi_mem_model #(
      .read_lat_p (g == 0 ? 8 : 1),
      .seed_p     (16'd41280)
    ) i_mem (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .aw_i       (aw[g]),
      .aw_v_i     (aw_v[g]),
      .aw_ready_o (aw_rdy[g]),
      .w_i        (w[g]),
      .w_v_i      (w_v[g]),
      .w_ready_o  (w_rdy[g]),
      .b_o        (b[g]),
      .b_v_o      (b_v[g]),
      .b_ready_i  (b_rdy[g]),
      .ar_i       (ar[g]),
      .ar_v_i     (ar_v[g]),
      .ar_ready_o (ar_rdy[g]),
      .r_o        (r[g]),
      .r_v_o      (r_v[g]),
      .r_ready_i  (r_rdy[g])
    );

    a_aw: assert property (@(posedge clk) disable iff (!arst_n)
      aw_v[g] |-> ax_any[g] && ax_head[g].w && (aw[g].addr == ax_head[g].addr) &&
      (aw[g].addr[`AB_LANE_BIT] == (g != 0)) && (aw[g].size == ax_head[g].size) &&
      (aw[g].len == 8'd0))
      else fail_run($sformatf("[ERROR] %0t: lane %0d AW does not match request", $time, g));
    a_ar: assert property (@(posedge clk) disable iff (!arst_n)
      ar_v[g] |-> ax_any[g] && !ax_head[g].w && (ar[g].addr == ax_head[g].addr) &&
      (ar[g].addr[`AB_LANE_BIT] == (g != 0)) && (ar[g].size == ax_head[g].size) &&
      (ar[g].len == 8'd0))
      else fail_run($sformatf("[ERROR] %0t: lane %0d AR does not match request", $time, g));
    a_w: assert property (@(posedge clk) disable iff (!arst_n)
      w_v[g] |-> wd_any[g] && w[g].last && (w[g].data == wd_head[g].data) &&
      (w[g].strb == byte_enables(wd_head[g].size, wd_head[g].addr[2:0])))
      else fail_run($sformatf("[ERROR] %0t: lane %0d W beat or strobe wrong", $time, g));
    a_b_ready: assert property (@(posedge clk) disable iff (!arst_n) b_rdy[g])
      else fail_run($sformatf("[ERROR] %0t: lane %0d BREADY is low", $time, g));
    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (aw_v[g] && !aw_rdy[g]) |=> aw_v[g] && $stable(aw[g]))
      else fail_run($sformatf("[ERROR] %0t: lane %0d AW changed while waiting", $time, g));
    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (w_v[g] && !w_rdy[g]) |=> w_v[g] && $stable(w[g]))
      else fail_run($sformatf("[ERROR] %0t: lane %0d W changed while waiting", $time, g));
    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (ar_v[g] && !ar_rdy[g]) |=> ar_v[g] && $stable(ar[g]))
      else fail_run($sformatf("[ERROR] %0t: lane %0d AR changed while waiting", $time, g));
  end

  initial begin : watchdog
    repeat (num_req_c * 50) @(posedge clk);
    fail_run($sformatf("timeout: run not finished after %0d cycles", num_req_c * 50));
  end

  initial begin : stimulus
    axi_bridge_pkg::fifo_req_t rq;
    logic [31:0]               v;
    lfsr       = 16'd41280;
    seen_req   = 1'b0;
    req_fire   = 1'b0;
    rsp_fire   = 1'b0;
    ax_fire    = '0;
    wd_fire    = '0;
    read_count = 0;
    rsp_count  = 0;
    req        = '0;
    req_v      = 1'b0;
    rsp_ready  = 1'b0;
    arst_n     = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int n = 0; n < num_req_c; n++) begin
      // half the time an idle gap of one or two cycles
      draw(2, v);
      if (v[1]) begin
        req_v = 1'b0;
        repeat (int'(v[0]) + 1) next_cycle();
      end
      rq = '0;
      draw(1, v);
      rq.w = v[0];
      draw(2, v);
      rq.size = 3'(v[1:0]);
      draw(1, v);
      rq.addr[`AB_LANE_BIT] = v[0];
      // eight words per lane so reads often hit earlier writes
      draw(3, v);
      rq.addr[5:3] = v[2:0];
      draw(3, v);
      rq.addr[2:0] = v[2:0] & ~((3'd1 << rq.size) - 3'd1);
      draw(32, v);
      rq.data[31:0] = v;
      draw(32, v);
      rq.data[63:32] = v;
      draw(8, v);
      rq.wmask = v[7:0];
      req   = rq;
      req_v = 1'b1;
      do begin
        next_cycle();
      end while (!req_fire);
    end
    req_v = 1'b0;
    // the last accepted request is booked on the coming falling edge
    next_cycle();
    while (rsp_count != read_count || ax_any != '0 || wd_any != '0) begin
      next_cycle();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: common/axi_bridge_defines.svh
// AXI bridge parameters
`ifndef AXI_BRIDGE_DEFINES_SVH
`define AXI_BRIDGE_DEFINES_SVH

// address and data path
`define AB_ADDR_W 32
`define AB_DATA_W 64
`define AB_STRB_W 8

// lanes, selected by one address bit
`define AB_LANES 2
`define AB_LANE_BIT 12

// reads outstanding across all lanes
`define AB_ORDER_DEPTH 4

`endif

// File: common/axi_bridge_pkg.sv
// AXI bridge types
`include "axi_bridge_defines.svh"

package axi_bridge_pkg;

  // lane index, wide enough for every lane
  typedef logic [$clog2(`AB_LANES)-1:0] lane_id_t;

  // client request, w set for a write
  typedef struct packed {
    logic [`AB_ADDR_W-1:0] addr;
    logic [`AB_DATA_W-1:0] data;
    logic [`AB_STRB_W-1:0] wmask;
    logic [2:0]            size;
    logic                  w;
  } fifo_req_t;

  // address channel, shared by AW and AR
  typedef struct packed {
    logic [`AB_ADDR_W-1:0] addr;
    logic                  id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic                  lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
    logic [3:0]            qos;
    logic [3:0]            region;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [`AB_DATA_W-1:0] data;
    logic [`AB_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [`AB_DATA_W-1:0] data;
    logic                  id;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    logic       id;
    logic [1:0] resp;
  } axi_b_t;

endpackage

// File: fifo_to_axi/fifo_to_axi_bridge.sv
// Request stream to AXI4 manager
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module fifo_to_axi_bridge (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  axi_bridge_pkg::fifo_req_t req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  output logic [`AB_DATA_W-1:0]     rsp_data_o,
  output logic                      rsp_v_o,
  input  logic                      rsp_ready_i,
  output axi_bridge_pkg::axi_aw_t   aw_o,
  output logic                      aw_v_o,
  input  logic                      aw_ready_i,
  output axi_bridge_pkg::axi_w_t    w_o,
  output logic                      w_v_o,
  input  logic                      w_ready_i,
  input  axi_bridge_pkg::axi_b_t    b_i,
  input  logic                      b_v_i,
  output logic                      b_ready_o,
  output axi_bridge_pkg::axi_ar_t   ar_o,
  output logic                      ar_v_o,
  input  logic                      ar_ready_i,
  input  axi_bridge_pkg::axi_r_t    r_i,
  input  logic                      r_v_i,
  output logic                      r_ready_o
);

  localparam int shift_w = $clog2(`AB_STRB_W);

  axi_bridge_pkg::fifo_req_t head;
  axi_bridge_pkg::axi_aw_t   ax;
  logic                      head_v;
  logic                      head_yumi;
  logic                      addr_sent_q;
  logic                      data_sent_q;
  logic [shift_w-1:0]        byte_off;
  logic [`AB_STRB_W-1:0]     strb;

  two_slot_fifo #(
    .width_p($bits(axi_bridge_pkg::fifo_req_t))
  ) i_req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (req_v_i),
    .data_i   (req_i),
    .ready_o  (req_ready_o),
    .v_o      (head_v),
    .data_o   (head),
    .yumi_i   (head_yumi)
  );

  // R data waits here for the merger and RREADY drops when full
  two_slot_fifo #(
    .width_p(`AB_DATA_W)
  ) i_rsp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (r_v_i),
    .data_i   (r_i.data),
    .ready_o  (r_ready_o),
    .v_o      (rsp_v_o),
    .data_o   (rsp_data_o),
    .yumi_i   (rsp_v_o & rsp_ready_i)
  );

  // write responses are taken and dropped
  assign b_ready_o = 1'b1;

  // release once address and, for writes, data have gone out
  assign head_yumi = head_v & addr_sent_q & (~head.w | data_sent_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_sent_q <= 1'b0;
      data_sent_q <= 1'b0;
    end else if (head_yumi) begin
      addr_sent_q <= 1'b0;
      data_sent_q <= 1'b0;
    end else begin
      if ((aw_v_o & aw_ready_i) | (ar_v_o & ar_ready_i)) begin
        addr_sent_q <= 1'b1;
      end
      if (w_v_o & w_ready_i) begin
        data_sent_q <= 1'b1;
      end
    end
  end

  assign byte_off = head.addr[shift_w-1:0];

  // byte lanes from size and offset
  always_comb begin
    case (head.size)
      3'd0:    strb = `AB_STRB_W'('h1) << byte_off;
      3'd1:    strb = `AB_STRB_W'('h3) << byte_off;
      3'd2:    strb = `AB_STRB_W'('hf) << byte_off;
      default: strb = '1;
    endcase
  end

  // single beat INCR with all other fields zero
  always_comb begin
    ax       = '0;
    ax.addr  = head.addr;
    ax.size  = head.size;
    ax.burst = 2'b01;
  end

  assign aw_o = ax;
  assign ar_o = ax;

  assign w_o.data = head.data;
  assign w_o.strb = strb;
  assign w_o.last = 1'b1;

  assign aw_v_o = head_v & head.w & ~addr_sent_q;
  assign w_v_o  = head_v & head.w & ~data_sent_q;
  assign ar_v_o = head_v & ~head.w & ~addr_sent_q;

  a_aw_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (aw_v_o && !aw_ready_i) |=> (aw_v_o && $stable(aw_o))
  ) else $error("fifo_to_axi_bridge: AW changed while waiting");

  // an aligned access keeps every one of its bytes inside the word
  a_w_strb: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    w_v_o |-> ($countones(w_o.strb) ==
               ((head.size > 3'd2) ? `AB_STRB_W : (1 << head.size)))
  ) else $error("fifo_to_axi_bridge: write strobe does not cover the access size");

  // the subordinate must echo the zero id on both response channels
  a_rsp_id_zero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (b_v_i |-> !b_i.id) and (r_v_i |-> !r_i.id)
  ) else $error("fifo_to_axi_bridge: nonzero response id");

endmodule

// File: source/axi_bridge_top.sv
// Two-lane AXI memory bridge
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module axi_bridge_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  axi_bridge_pkg::fifo_req_t req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  output logic [`AB_DATA_W-1:0]     rsp_data_o,
  output logic                      rsp_v_o,
  input  logic                      rsp_ready_i,
  output axi_bridge_pkg::axi_aw_t   aw_o [`AB_LANES],
  output logic [`AB_LANES-1:0]      aw_v_o,
  input  logic [`AB_LANES-1:0]      aw_ready_i,
  output axi_bridge_pkg::axi_w_t    w_o [`AB_LANES],
  output logic [`AB_LANES-1:0]      w_v_o,
  input  logic [`AB_LANES-1:0]      w_ready_i,
  input  axi_bridge_pkg::axi_b_t    b_i [`AB_LANES],
  input  logic [`AB_LANES-1:0]      b_v_i,
  output logic [`AB_LANES-1:0]      b_ready_o,
  output axi_bridge_pkg::axi_ar_t   ar_o [`AB_LANES],
  output logic [`AB_LANES-1:0]      ar_v_o,
  input  logic [`AB_LANES-1:0]      ar_ready_i,
  input  axi_bridge_pkg::axi_r_t    r_i [`AB_LANES],
  input  logic [`AB_LANES-1:0]      r_v_i,
  output logic [`AB_LANES-1:0]      r_ready_o
);

  axi_bridge_pkg::fifo_req_t lane_req [`AB_LANES];
  logic [`AB_LANES-1:0]      lane_v;
  logic [`AB_LANES-1:0]      lane_ready;
  logic [`AB_DATA_W-1:0]     lane_rsp_data [`AB_LANES];
  logic [`AB_LANES-1:0]      lane_rsp_v;
  logic [`AB_LANES-1:0]      lane_rsp_ready;
  logic                      order_push;
  logic                      order_ready;
  axi_bridge_pkg::lane_id_t  order_lane;

  lane_splitter i_splitter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .req_v_i       (req_v_i),
    .req_ready_o   (req_ready_o),
    .lane_req_o    (lane_req),
    .lane_v_o      (lane_v),
    .lane_ready_i  (lane_ready),
    .order_ready_i (order_ready),
    .order_push_o  (order_push),
    .order_lane_o  (order_lane)
  );

  // one bridge and AXI port per lane
  for (genvar g = 0; g < `AB_LANES; g++) begin : g_lane
    fifo_to_axi_bridge i_bridge (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (lane_req[g]),
      .req_v_i     (lane_v[g]),
      .req_ready_o (lane_ready[g]),
      .rsp_data_o  (lane_rsp_data[g]),
      .rsp_v_o     (lane_rsp_v[g]),
      .rsp_ready_i (lane_rsp_ready[g]),
      .aw_o        (aw_o[g]),
      .aw_v_o      (aw_v_o[g]),
      .aw_ready_i  (aw_ready_i[g]),
      .w_o         (w_o[g]),
      .w_v_o       (w_v_o[g]),
      .w_ready_i   (w_ready_i[g]),
      .b_i         (b_i[g]),
      .b_v_i       (b_v_i[g]),
      .b_ready_o   (b_ready_o[g]),
      .ar_o        (ar_o[g]),
      .ar_v_o      (ar_v_o[g]),
      .ar_ready_i  (ar_ready_i[g]),
      .r_i         (r_i[g]),
      .r_v_i       (r_v_i[g]),
      .r_ready_o   (r_ready_o[g])
    );
  end

  read_merger i_merger (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .order_push_i     (order_push),
    .order_lane_i     (order_lane),
    .order_ready_o    (order_ready),
    .lane_rsp_data_i  (lane_rsp_data),
    .lane_rsp_v_i     (lane_rsp_v),
    .lane_rsp_ready_o (lane_rsp_ready),
    .rsp_data_o       (rsp_data_o),
    .rsp_v_o          (rsp_v_o),
    .rsp_ready_i      (rsp_ready_i)
  );

endmodule

// File: source/lane_splitter.sv
// Request lane splitter
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module lane_splitter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  axi_bridge_pkg::fifo_req_t req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  output axi_bridge_pkg::fifo_req_t lane_req_o [`AB_LANES],
  output logic [`AB_LANES-1:0]      lane_v_o,
  input  logic [`AB_LANES-1:0]      lane_ready_i,
  input  logic                      order_ready_i,
  output logic                      order_push_o,
  output axi_bridge_pkg::lane_id_t  order_lane_o
);

  axi_bridge_pkg::lane_id_t sel;
  logic                     room;

  // lane from the address
  assign sel = req_i.addr[`AB_LANE_BIT +: $bits(axi_bridge_pkg::lane_id_t)];

  // a read also needs a free slot in the order queue
  assign room = req_i.w | order_ready_i;

  always_comb begin
    for (int l = 0; l < `AB_LANES; l++) begin
      lane_req_o[l] = req_i;
      lane_v_o[l]   = req_v_i & room & (sel == axi_bridge_pkg::lane_id_t'(l));
    end
  end

  assign req_ready_o = lane_ready_i[sel] & room;

  // record which lane each accepted read went to
  assign order_push_o = req_v_i & ~req_i.w & order_ready_i & lane_ready_i[sel];
  assign order_lane_o = sel;

  // a waiting offer stays on its lane until that lane takes it
  a_lane_v_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (|lane_v_o && !req_ready_o) |=> (lane_v_o == $past(lane_v_o))
  ) else $error("lane_splitter: pending request moved off its lane");

endmodule

// File: source/read_merger.sv
// In-order read merger
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module read_merger (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     order_push_i,
  input  axi_bridge_pkg::lane_id_t order_lane_i,
  output logic                     order_ready_o,
  input  logic [`AB_DATA_W-1:0]    lane_rsp_data_i [`AB_LANES],
  input  logic [`AB_LANES-1:0]     lane_rsp_v_i,
  output logic [`AB_LANES-1:0]     lane_rsp_ready_o,
  output logic [`AB_DATA_W-1:0]    rsp_data_o,
  output logic                     rsp_v_o,
  input  logic                     rsp_ready_i
);

  localparam int ptr_w = $clog2(`AB_ORDER_DEPTH);
  localparam int cnt_w = $clog2(`AB_ORDER_DEPTH + 1);

  axi_bridge_pkg::lane_id_t order_q [`AB_ORDER_DEPTH];
  axi_bridge_pkg::lane_id_t head;
  logic [ptr_w-1:0]         wptr_q;
  logic [ptr_w-1:0]         rptr_q;
  logic [cnt_w-1:0]         count_q;
  logic                     empty;
  logic                     pop;

  assign empty         = (count_q == '0);
  assign order_ready_o = (count_q != cnt_w'(`AB_ORDER_DEPTH));
  assign head          = order_q[rptr_q];

  // only the oldest read's lane may hand over data
  assign rsp_data_o = lane_rsp_data_i[head];
  assign rsp_v_o    = ~empty & lane_rsp_v_i[head];
  assign pop        = rsp_v_o & rsp_ready_i;

  always_comb begin
    for (int l = 0; l < `AB_LANES; l++) begin
      lane_rsp_ready_o[l] = ~empty & rsp_ready_i & (head == axi_bridge_pkg::lane_id_t'(l));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (order_push_i) begin
        wptr_q <= (wptr_q == ptr_w'(`AB_ORDER_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == ptr_w'(`AB_ORDER_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({order_push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // lane ids of the reads in flight
  always_ff @(posedge clk_i) begin
    if (order_push_i) begin
      order_q[wptr_q] <= order_lane_i;
    end
  end

  // read data in any lane with no read on record would mean a lost pop
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (|lane_rsp_v_i) |-> !empty
  ) else $error("read_merger: lane data with empty order queue");

endmodule

// File: source/two_slot_fifo.sv
// Two entry buffer
`timescale 1ns/1ps
`include "axi_bridge_defines.svh"

module two_slot_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0] mem_q [2];
  logic               wptr_q;
  logic               rptr_q;
  logic [1:0]         count_q;
  logic               enq;

  assign ready_o = (count_q != 2'd2);
  assign v_o     = (count_q != 2'd0);
  assign data_o  = mem_q[rptr_q];
  assign enq     = v_i & ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (enq) begin
        wptr_q <= ~wptr_q;
      end
      if (yumi_i) begin
        rptr_q <= ~rptr_q;
      end
      case ({enq, yumi_i})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  // consumer must not take from an empty buffer
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) yumi_i |-> v_o
  ) else $error("two_slot_fifo: yumi while empty");

endmodule

// File: sources.f
+incdir+common
common/axi_bridge_pkg.sv
source/two_slot_fifo.sv
fifo_to_axi/fifo_to_axi_bridge.sv
source/lane_splitter.sv
source/read_merger.sv
source/axi_bridge_top.sv
bench/axi_mem_model.sv
bench/tb_axi_bridge.sv
